// File: hw/dma_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Master port widths. Transfers are whole 32-bit words only
//////////////////////////////////////////////////////////////////////

package dma_bus_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // Address step between two consecutive words
  localparam int WORD_BYTES = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

// File: hw/dma_reg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Register map of the channel. Offsets are byte offsets, word aligned
//////////////////////////////////////////////////////////////////////

package dma_reg_pkg;

  localparam int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam reg_addr_t SRC_PTR_OFS = 5'h00;
  localparam reg_addr_t DST_PTR_OFS = 5'h04;
  localparam reg_addr_t SIZE_OFS    = 5'h08;
  localparam reg_addr_t MODE_OFS    = 5'h0C;
  localparam reg_addr_t INTR_EN_OFS = 5'h10;
  // Read-only, bit 0 is ready
  localparam reg_addr_t STATUS_OFS  = 5'h14;
  // Transaction flag, cleared by a read
  localparam reg_addr_t IFR_OFS     = 5'h18;

  // Values of the mode register
  localparam logic MODE_SINGLE   = 1'b0;
  localparam logic MODE_CIRCULAR = 1'b1;

endpackage

// File: hw/dma_regs.sv
//////////////////////////////////////////////////////////////////////
// Readback is combinational on the address. Only a read of IFR has a side effect
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_regs
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;
(
  input  logic      clk_cg,
  input  logic      rst_ni,
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  data_t     reg_wdata_i,
  output data_t     reg_rdata_o,
  input  logic      ready_i,
  input  logic      ifr_i,
  output addr_t     src_ptr_o,
  output addr_t     dst_ptr_o,
  output data_t     size_o,
  output logic      circular_o,
  output logic      intr_en_o,
  output logic      size_wr_o,
  output logic      ifr_rd_o
);

  addr_t src_ptr_q;
  addr_t dst_ptr_q;
  data_t size_q;
  logic  mode_q;
  logic  intr_en_q;

  always_ff @(posedge clk_cg or negedge rst_ni) begin
    if (!rst_ni) begin
      src_ptr_q <= '0;
      dst_ptr_q <= '0;
      size_q    <= '0;
      mode_q    <= MODE_SINGLE;
      intr_en_q <= 1'b0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        SRC_PTR_OFS: src_ptr_q <= reg_wdata_i;
        DST_PTR_OFS: dst_ptr_q <= reg_wdata_i;
        SIZE_OFS:    size_q    <= reg_wdata_i;
        MODE_OFS:    mode_q    <= reg_wdata_i[0];
        INTR_EN_OFS: intr_en_q <= reg_wdata_i[0];
        default:     ;
      endcase
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      SRC_PTR_OFS: reg_rdata_o = src_ptr_q;
      DST_PTR_OFS: reg_rdata_o = dst_ptr_q;
      SIZE_OFS:    reg_rdata_o = size_q;
      MODE_OFS:    reg_rdata_o[0] = mode_q;
      INTR_EN_OFS: reg_rdata_o[0] = intr_en_q;
      STATUS_OFS:  reg_rdata_o[0] = ready_i;
      IFR_OFS:     reg_rdata_o[0] = ifr_i;
      default:     reg_rdata_o = '0;
    endcase
  end

  // A zero size is accepted but does not start anything
  assign size_wr_o  = reg_we_i && (reg_addr_i == SIZE_OFS) && (reg_wdata_i != '0);
  assign ifr_rd_o   = reg_re_i && (reg_addr_i == IFR_OFS);

  assign src_ptr_o  = src_ptr_q;
  assign dst_ptr_o  = dst_ptr_q;
  assign size_o     = size_q;
  assign circular_o = (mode_q == MODE_CIRCULAR);
  assign intr_en_o  = intr_en_q;

endmodule

// File: hw/dma_ctrl.sv
//////////////////////////////////////////////////////////////////////
// The flag only moves while the interrupt is enabled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_ctrl (
  input  logic clk_cg,
  input  logic rst_ni,
  input  logic size_wr_i,
  input  logic circular_i,
  input  logic intr_en_i,
  input  logic ifr_rd_i,
  input  logic dma_done_i,
  output logic dma_start_o,
  output logic running_o,
  output logic ready_o,
  output logic ifr_o,
  output logic dma_done_intr_o
);

  typedef enum logic [1:0] {
    ST_READY,
    ST_STARTING,
    ST_RUNNING
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   start_pending_q;
  logic   ifr_q;
  logic   intr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_READY:    if (start_pending_q) state_d = ST_STARTING;
      // Loading the units takes exactly one cycle
      ST_STARTING: state_d = ST_RUNNING;
      ST_RUNNING: begin
        if (dma_done_i) begin
          state_d = circular_i ? ST_STARTING : ST_READY;
        end
      end
      default:     state_d = ST_READY;
    endcase
  end

  always_ff @(posedge clk_cg or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= ST_READY;
      start_pending_q <= 1'b0;
      ifr_q           <= 1'b0;
      intr_q          <= 1'b0;
    end else begin
      state_q <= state_d;
      // A SIZE write during a transfer is held until the channel is ready again
      if (dma_start_o) begin
        start_pending_q <= 1'b0;
      end else if (size_wr_i) begin
        start_pending_q <= 1'b1;
      end
      // Done wins over a read that lands in the same cycle
      if (intr_en_i) begin
        if (dma_done_i) begin
          ifr_q <= 1'b1;
        end else if (ifr_rd_i) begin
          ifr_q <= 1'b0;
        end
      end
      intr_q <= ifr_q;
    end
  end

  assign dma_start_o     = (state_q == ST_STARTING);
  assign running_o       = (state_q == ST_RUNNING);
  assign ready_o         = (state_q == ST_READY);
  assign ifr_o           = ifr_q;
  assign dma_done_intr_o = intr_q;

endmodule

// File: hw/dma_fifo.sv
//////////////////////////////////////////////////////////////////////
// FIFO_DEPTH must be a power of two. The user must not push when full
// or pop when empty
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_fifo
  import dma_bus_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  localparam int PTR_W = $clog2(FIFO_DEPTH),
  localparam int LVL_W = PTR_W + 1
) (
  input  logic             clk_cg,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  data_t            push_data_i,
  input  logic             pop_i,
  output data_t            pop_data_o,
  output logic             empty_o,
  output logic [LVL_W-1:0] level_o
);

  data_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0] level_q;

  always_ff @(posedge clk_cg) begin
    if (push_i && !flush_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_cg or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (flush_i) begin
      // Flush takes priority over a push or pop in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      level_q <= level_q + LVL_W'(push_i) - LVL_W'(pop_i);
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (level_q == '0);
  assign level_o    = level_q;

endmodule

// File: hw/dma_read_unit.sv
//////////////////////////////////////////////////////////////////////
// Reads are word aligned and must return in order. Data from reads that
// were in flight at a restart is dropped
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_read_unit
  import dma_bus_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1
) (
  input  logic             clk_cg,
  input  logic             rst_ni,
  input  logic             dma_start_i,
  input  logic             running_i,
  input  logic             ext_dma_stop_i,
  input  addr_t            src_ptr_i,
  input  data_t            size_i,
  input  logic [LVL_W-1:0] fifo_level_i,
  output logic             rd_req_o,
  output addr_t            rd_addr_o,
  input  logic             rd_gnt_i,
  input  logic             rd_rvalid_i,
  output logic             push_o
);

  addr_t            rd_addr_q;
  data_t            words_left_q;
  logic [LVL_W-1:0] outstanding_q;
  logic [LVL_W-1:0] discard_q;
  logic             stopped_q;
  logic [LVL_W:0]   committed;
  logic             issue;

  // Every read in flight already owns a FIFO slot, so a push always fits
  assign committed = {1'b0, outstanding_q} + {1'b0, fifo_level_i};
  assign rd_req_o  = running_i && !stopped_q && (words_left_q != '0) &&
                     (committed < (LVL_W + 1)'(FIFO_DEPTH));
  assign rd_addr_o = rd_addr_q;
  assign issue     = rd_req_o && rd_gnt_i;
  assign push_o    = rd_rvalid_i && (discard_q == '0);

  always_ff @(posedge clk_cg or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_addr_q     <= '0;
      words_left_q  <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
      stopped_q     <= 1'b0;
    end else begin
      outstanding_q <= outstanding_q + LVL_W'(issue) - LVL_W'(rd_rvalid_i);
      if (dma_start_i) begin
        rd_addr_q    <= src_ptr_i;
        words_left_q <= size_i;
        stopped_q    <= 1'b0;
        // Responses still owed to the previous run must not reach the new one
        discard_q    <= outstanding_q - LVL_W'(rd_rvalid_i);
      end else begin
        if (issue) begin
          rd_addr_q    <= rd_addr_q + ADDR_W'(WORD_BYTES);
          words_left_q <= words_left_q - 1'b1;
        end
        if (rd_rvalid_i && (discard_q != '0)) discard_q <= discard_q - 1'b1;
        if (ext_dma_stop_i && running_i) stopped_q <= 1'b1;
      end
    end
  end

endmodule

// File: hw/dma_write_unit.sv
//////////////////////////////////////////////////////////////////////
// Writes go out strictly in FIFO order to consecutive word addresses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_write_unit
  import dma_bus_pkg::*;
(
  input  logic  clk_cg,
  input  logic  rst_ni,
  input  logic  dma_start_i,
  input  logic  running_i,
  input  logic  ext_dma_stop_i,
  input  addr_t dst_ptr_i,
  input  data_t size_i,
  input  logic  fifo_empty_i,
  input  data_t fifo_data_i,
  output logic  wr_req_o,
  output addr_t wr_addr_o,
  output data_t wr_wdata_o,
  input  logic  wr_gnt_i,
  output logic  pop_o,
  output logic  dma_done_o
);

  addr_t wr_addr_q;
  data_t words_left_q;
  logic  done_q;
  logic  last_gnt;
  logic  stop_seen;

  // Nothing more is written once done has been flagged
  assign wr_req_o   = running_i && !done_q && !fifo_empty_i && (words_left_q != '0);
  assign wr_addr_o  = wr_addr_q;
  assign wr_wdata_o = fifo_data_i;
  assign pop_o      = wr_req_o && wr_gnt_i;
  assign last_gnt   = pop_o && (words_left_q == DATA_W'(1));
  assign stop_seen  = running_i && ext_dma_stop_i;
  assign dma_done_o = done_q;

  always_ff @(posedge clk_cg or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_addr_q    <= '0;
      words_left_q <= '0;
      done_q       <= 1'b0;
    end else begin
      if (dma_start_i) begin
        wr_addr_q    <= dst_ptr_i;
        words_left_q <= size_i;
      end else if (pop_o) begin
        wr_addr_q    <= wr_addr_q + ADDR_W'(WORD_BYTES);
        words_left_q <= words_left_q - 1'b1;
      end
      // Single-cycle pulse, a held stop does not repeat it
      done_q <= !done_q && (last_gnt || stop_seen);
    end
  end

endmodule

// File: hw/dma_channel.sv
//////////////////////////////////////////////////////////////////////
// Single channel, runs entirely on clk_cg. FIFO_DEPTH is a power of two
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dma_channel
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1
) (
  input  logic      clk_cg,
  input  logic      rst_ni,
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  data_t     reg_wdata_i,
  output data_t     reg_rdata_o,
  output logic      rd_req_o,
  output addr_t     rd_addr_o,
  input  logic      rd_gnt_i,
  input  logic      rd_rvalid_i,
  input  data_t     rd_rdata_i,
  output logic      wr_req_o,
  output addr_t     wr_addr_o,
  output data_t     wr_wdata_o,
  input  logic      wr_gnt_i,
  input  logic      ext_dma_stop_i,
  output logic      dma_done_o,
  output logic      dma_done_intr_o
);

  addr_t            src_ptr;
  addr_t            dst_ptr;
  data_t            size;
  logic             circular;
  logic             intr_en;
  logic             size_wr;
  logic             ifr_rd;
  logic             ready;
  logic             ifr;
  logic             dma_start;
  logic             running;
  logic             dma_done;
  logic             fifo_push;
  logic             fifo_pop;
  data_t            fifo_data;
  logic             fifo_empty;
  logic [LVL_W-1:0] fifo_level;

  dma_regs u_regs (
    .clk_cg      (clk_cg),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .ready_i     (ready),
    .ifr_i       (ifr),
    .src_ptr_o   (src_ptr),
    .dst_ptr_o   (dst_ptr),
    .size_o      (size),
    .circular_o  (circular),
    .intr_en_o   (intr_en),
    .size_wr_o   (size_wr),
    .ifr_rd_o    (ifr_rd)
  );

  dma_ctrl u_ctrl (
    .clk_cg          (clk_cg),
    .rst_ni          (rst_ni),
    .size_wr_i       (size_wr),
    .circular_i      (circular),
    .intr_en_i       (intr_en),
    .ifr_rd_i        (ifr_rd),
    .dma_done_i      (dma_done),
    .dma_start_o     (dma_start),
    .running_o       (running),
    .ready_o         (ready),
    .ifr_o           (ifr),
    .dma_done_intr_o (dma_done_intr_o)
  );

  // Each start flushes leftovers of a stopped run
  dma_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_cg      (clk_cg),
    .rst_ni      (rst_ni),
    .flush_i     (dma_start),
    .push_i      (fifo_push),
    .push_data_i (rd_rdata_i),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_data),
    .empty_o     (fifo_empty),
    .level_o     (fifo_level)
  );

  dma_read_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_read (
    .clk_cg         (clk_cg),
    .rst_ni         (rst_ni),
    .dma_start_i    (dma_start),
    .running_i      (running),
    .ext_dma_stop_i (ext_dma_stop_i),
    .src_ptr_i      (src_ptr),
    .size_i         (size),
    .fifo_level_i   (fifo_level),
    .rd_req_o       (rd_req_o),
    .rd_addr_o      (rd_addr_o),
    .rd_gnt_i       (rd_gnt_i),
    .rd_rvalid_i    (rd_rvalid_i),
    .push_o         (fifo_push)
  );

  dma_write_unit u_write (
    .clk_cg         (clk_cg),
    .rst_ni         (rst_ni),
    .dma_start_i    (dma_start),
    .running_i      (running),
    .ext_dma_stop_i (ext_dma_stop_i),
    .dst_ptr_i      (dst_ptr),
    .size_i         (size),
    .fifo_empty_i   (fifo_empty),
    .fifo_data_i    (fifo_data),
    .wr_req_o       (wr_req_o),
    .wr_addr_o      (wr_addr_o),
    .wr_wdata_o     (wr_wdata_o),
    .wr_gnt_i       (wr_gnt_i),
    .pop_o          (fifo_pop),
    .dma_done_o     (dma_done)
  );

  assign dma_done_o = dma_done;

endmodule

// File: bench/tb_dma_channel.sv
//////////////////////////////////////////////////////////////////////
// Directed tests with a memory model on both master ports. The
// destination window holds 64 words starting at DST_BASE
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_dma_channel
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;
();

  localparam int    FIFO_DEPTH  = 4;
  localparam int    DST_WORDS   = 64;
  localparam int    WAIT_CYCLES = 2000;
  localparam addr_t SRC_BASE    = 32'h0000_1000;
  localparam addr_t DST_BASE    = 32'h0002_0000;

  logic      clk_cg;
  logic      rst_ni;
  logic      reg_we_i;
  logic      reg_re_i;
  reg_addr_t reg_addr_i;
  data_t     reg_wdata_i;
  data_t     reg_rdata_o;
  logic      rd_req_o;
  addr_t     rd_addr_o;
  logic      rd_gnt_i;
  logic      rd_rvalid_i;
  data_t     rd_rdata_i;
  logic      wr_req_o;
  addr_t     wr_addr_o;
  data_t     wr_wdata_o;
  logic      wr_gnt_i;
  logic      ext_dma_stop_i;
  logic      dma_done_o;
  logic      dma_done_intr_o;

  logic [31:0] rng_state = 32'd16655;
  logic [31:0] rnd;
  bit          random_on = 1'b0;
  int          errors = 0;
  int          timeouts = 0;
  int          outstanding = 0;
  int          done_cnt = 0;
  int          dst_cnt = 0;
  data_t       dst_mem [DST_WORDS];
  int          dst_hits [DST_WORDS];
  addr_t       pend_addr [$];

  dma_channel #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .clk_cg          (clk_cg),
    .rst_ni          (rst_ni),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .rd_req_o        (rd_req_o),
    .rd_addr_o       (rd_addr_o),
    .rd_gnt_i        (rd_gnt_i),
    .rd_rvalid_i     (rd_rvalid_i),
    .rd_rdata_i      (rd_rdata_i),
    .wr_req_o        (wr_req_o),
    .wr_addr_o       (wr_addr_o),
    .wr_wdata_o      (wr_wdata_o),
    .wr_gnt_i        (wr_gnt_i),
    .ext_dma_stop_i  (ext_dma_stop_i),
    .dma_done_o      (dma_done_o),
    .dma_done_intr_o (dma_done_intr_o)
  );

  initial begin
    clk_cg = 1'b0;
    forever #2 clk_cg = ~clk_cg;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Source memory content depends on every address bit
  function automatic data_t source_word(addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  task automatic flag_error(string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic note_timeout(string what);
    timeouts++;
    $display("Timeout: gave up waiting for %s at time %0t", what, $time);
  endtask

  task automatic record_write(addr_t a, data_t d);
    addr_t ofs;
    int    idx;
    ofs = a - DST_BASE;
    idx = int'(ofs >> 2);
    if (a < DST_BASE || ofs >= addr_t'(DST_WORDS * WORD_BYTES) || a[1:0] != 2'b00) begin
      flag_error($sformatf("write to unexpected address 0x%08h", a));
    end else begin
      dst_mem[idx] = d;
      dst_hits[idx]++;
      dst_cnt++;
    end
  endtask

  // Both master ports. Reads answer in order with one cycle or more of latency
  initial begin
    rd_gnt_i    = 1'b0;
    rd_rvalid_i = 1'b0;
    rd_rdata_i  = '0;
    wr_gnt_i    = 1'b0;
    forever begin
      @(posedge clk_cg);
      if (rd_rvalid_i) outstanding--;
      if (rd_req_o && rd_gnt_i) begin
        pend_addr.push_back(rd_addr_o);
        outstanding++;
      end
      if (outstanding > FIFO_DEPTH) begin
        flag_error($sformatf("%0d reads outstanding, above FIFO_DEPTH", outstanding));
      end
      if (wr_req_o && wr_gnt_i) record_write(wr_addr_o, wr_wdata_o);
      if (dma_done_o) done_cnt++;
      rnd = next_random();
      rd_gnt_i <= random_on ? (rnd[1:0] != 2'b00) : 1'b1;
      wr_gnt_i <= random_on ? (rnd[3:2] != 2'b00) : 1'b1;
      if (pend_addr.size() > 0 && (!random_on || rnd[6:4] > 3'd2)) begin
        rd_rvalid_i <= 1'b1;
        rd_rdata_i  <= source_word(pend_addr.pop_front());
      end else begin
        rd_rvalid_i <= 1'b0;
        rd_rdata_i  <= '0;
      end
    end
  end

  task automatic reg_write(reg_addr_t a, data_t d);
    @(posedge clk_cg);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= a;
    reg_wdata_i <= d;
    @(posedge clk_cg);
    reg_we_i    <= 1'b0;
  endtask

  task automatic reg_read(reg_addr_t a, output data_t d);
    @(posedge clk_cg);
    reg_re_i   <= 1'b1;
    reg_addr_i <= a;
    @(posedge clk_cg);
    d = reg_rdata_o;
    reg_re_i   <= 1'b0;
  endtask

  task automatic read_and_compare(reg_addr_t a, data_t exp, string what);
    data_t d;
    reg_read(a, d);
    if (d !== exp) flag_error($sformatf("%s read 0x%08h, expected 0x%08h", what, d, exp));
  endtask

  task automatic clear_dest();
    for (int i = 0; i < DST_WORDS; i++) begin
      dst_mem[i]  = '0;
      dst_hits[i] = 0;
    end
    dst_cnt  = 0;
    done_cnt = 0;
  endtask

  task automatic start_copy(int n);
    reg_write(SRC_PTR_OFS, SRC_BASE);
    reg_write(DST_PTR_OFS, DST_BASE);
    reg_write(SIZE_OFS, data_t'(n));
  endtask

  task automatic wait_for_done(output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_CYCLES) begin
      @(posedge clk_cg);
      cycles++;
      if (dma_done_o) ok = 1'b1;
    end
    if (!ok) note_timeout("dma_done_o");
  endtask

  task automatic wait_for_ready(output bit ok);
    data_t d;
    int    polls;
    ok = 1'b0;
    polls = 0;
    while (!ok && polls < WAIT_CYCLES) begin
      reg_read(STATUS_OFS, d);
      polls++;
      ok = d[0];
    end
    if (!ok) note_timeout("STATUS to show ready");
  endtask

  // Word i of the destination must hold source word i
  task automatic check_dest(int n, bit exact);
    data_t exp;
    for (int i = 0; i < n; i++) begin
      exp = source_word(SRC_BASE + addr_t'(i * WORD_BYTES));
      if (dst_hits[i] == 0) begin
        flag_error($sformatf("destination word %0d was never written", i));
      end else if (dst_mem[i] !== exp) begin
        flag_error($sformatf("destination word %0d is 0x%08h, expected 0x%08h",
                             i, dst_mem[i], exp));
      end
      if (exact && dst_hits[i] > 1) begin
        flag_error($sformatf("destination word %0d written %0d times", i, dst_hits[i]));
      end
    end
    if (n < DST_WORDS && dst_hits[n] != 0) begin
      flag_error($sformatf("destination word %0d written past the end", n));
    end
  endtask

  task automatic test_register_readback();
    if (rd_req_o || wr_req_o || dma_done_o || dma_done_intr_o) begin
      flag_error("a request or done output is high after reset");
    end
    read_and_compare(STATUS_OFS, 32'h1, "STATUS after reset");
    reg_write(SRC_PTR_OFS, 32'h1234_5678);
    reg_write(DST_PTR_OFS, 32'h9ABC_DEF0);
    reg_write(MODE_OFS, data_t'(MODE_CIRCULAR));
    reg_write(INTR_EN_OFS, 32'h1);
    read_and_compare(SRC_PTR_OFS, 32'h1234_5678, "SRC_PTR");
    read_and_compare(DST_PTR_OFS, 32'h9ABC_DEF0, "DST_PTR");
    read_and_compare(MODE_OFS, data_t'(MODE_CIRCULAR), "MODE");
    read_and_compare(INTR_EN_OFS, 32'h1, "INTR_EN");
    reg_write(MODE_OFS, data_t'(MODE_SINGLE));
    reg_write(INTR_EN_OFS, 32'h0);
    read_and_compare(MODE_OFS, data_t'(MODE_SINGLE), "MODE after clear");
  endtask

  task automatic copy_and_check(int n, bit rand_en, string name);
    bit ok;
    random_on = rand_en;
    clear_dest();
    start_copy(n);
    wait_for_done(ok);
    if (!ok) return;
    wait_for_ready(ok);
    if (!ok) return;
    if (done_cnt != 1) begin
      flag_error($sformatf("%s pulsed dma_done_o %0d times, expected once", name, done_cnt));
    end
    check_dest(n, 1'b1);
  endtask

  task automatic test_interrupt();
    bit ok;
    int cycles;
    random_on = 1'b0;
    reg_write(INTR_EN_OFS, 32'h1);
    clear_dest();
    start_copy(4);
    wait_for_done(ok);
    if (!ok) return;
    cycles = 0;
    while (!dma_done_intr_o && cycles < 10) begin
      @(posedge clk_cg);
      cycles++;
    end
    if (!dma_done_intr_o) begin
      note_timeout("dma_done_intr_o to rise");
      return;
    end
    if (cycles != 2) flag_error($sformatf("interrupt rose %0d cycles after done", cycles));
    read_and_compare(IFR_OFS, 32'h1, "IFR after done");
    read_and_compare(IFR_OFS, 32'h0, "IFR after clearing read");
    cycles = 0;
    while (dma_done_intr_o && cycles < 10) begin
      @(posedge clk_cg);
      cycles++;
    end
    if (dma_done_intr_o) note_timeout("dma_done_intr_o to fall");
    wait_for_ready(ok);
    if (!ok) return;
    // Same transfer again with the interrupt masked
    reg_write(INTR_EN_OFS, 32'h0);
    clear_dest();
    start_copy(4);
    wait_for_done(ok);
    if (!ok) return;
    repeat (4) begin
      @(posedge clk_cg);
      if (dma_done_intr_o) flag_error("dma_done_intr_o high with the interrupt disabled");
    end
    read_and_compare(IFR_OFS, 32'h0, "IFR with interrupt disabled");
    wait_for_ready(ok);
  endtask

  task automatic test_circular();
    bit ok;
    random_on = 1'b1;
    reg_write(MODE_OFS, data_t'(MODE_CIRCULAR));
    clear_dest();
    start_copy(5);
    wait_for_done(ok);
    if (!ok) return;
    wait_for_done(ok);
    if (!ok) return;
    reg_write(MODE_OFS, data_t'(MODE_SINGLE));
    wait_for_ready(ok);
    if (!ok) return;
    if (done_cnt < 2) flag_error($sformatf("circular mode gave %0d done pulses", done_cnt));
    // Every run copies the same five words again
    if (dst_cnt != 5 * done_cnt) begin
      flag_error($sformatf("circular mode wrote %0d words in %0d runs", dst_cnt, done_cnt));
    end
    check_dest(5, 1'b0);
  endtask

  task automatic test_external_stop();
    bit ok;
    int grants;
    int cycles;
    random_on = 1'b1;
    clear_dest();
    start_copy(40);
    grants = 0;
    cycles = 0;
    while (grants < 8 && cycles < WAIT_CYCLES) begin
      @(posedge clk_cg);
      cycles++;
      if (wr_req_o && wr_gnt_i) grants++;
    end
    if (grants < 8) begin
      note_timeout("eight destination writes");
      return;
    end
    ext_dma_stop_i <= 1'b1;
    @(posedge clk_cg);
    ext_dma_stop_i <= 1'b0;
    wait_for_done(ok);
    if (!ok) return;
    wait_for_ready(ok);
    if (!ok) return;
    if (done_cnt != 1) flag_error($sformatf("stop gave %0d done pulses", done_cnt));
    if (dst_cnt >= 40) flag_error($sformatf("%0d words written despite the stop", dst_cnt));
    check_dest(dst_cnt, 1'b1);
  endtask

  initial begin
    rst_ni         = 1'b0;
    reg_we_i       = 1'b0;
    reg_re_i       = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    ext_dma_stop_i = 1'b0;
    repeat (4) @(posedge clk_cg);
    rst_ni <= 1'b1;
    test_register_readback();
    copy_and_check(7, 1'b0, "single copy");
    copy_and_check(16, 1'b1, "back-pressure copy");
    test_interrupt();
    test_circular();
    test_external_stop();
    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
hw/dma_bus_pkg.sv
hw/dma_reg_pkg.sv
hw/dma_regs.sv
hw/dma_ctrl.sv
hw/dma_fifo.sv
hw/dma_read_unit.sv
hw/dma_write_unit.sv
hw/dma_channel.sv
bench/tb_dma_channel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_channel
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	  echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
